/* build.f */
hdl/refill_pkg.sv
hdl/burst_sequencer.sv
hdl/bank_lane.sv
hdl/line_assembler.sv
hdl/refill_top.sv
sim/ahb_bank_model.sv
sim/tb_refill_top.sv

/* hdl/bank_lane.sv */
`timescale 1ns/10ps

// ==========================================================================
// Bank lane
// Address phase and data-phase tracking for one AHB bank
// ==========================================================================

module bank_lane import refill_pkg::*; #(
	parameter int BANK_ID = 0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// From the sequencer
	input  logic [LINE_BASE_W-1:0] i_line_base,
	input  logic [BEAT_IDX_W-1:0]  i_word_idx,
	input  htrans_t                i_htrans,
	// AHB slave side
	input  logic                   i_hready,
	input  logic                   i_hresp,
	input  logic [DATA_W-1:0]      i_hrdata,
	// AHB master side
	output logic [ADDR_W-1:0]      o_haddr,
	output htrans_t                o_htrans,
	output logic [2:0]             o_hburst,
	output logic [2:0]             o_hsize,
	output logic                   o_hwrite,
	// Data-phase result
	output logic                   o_beat_valid,
	output logic [BEAT_IDX_W-1:0]  o_beat_idx,
	output logic                   o_beat_err,
	output logic [DATA_W-1:0]      o_beat_data
);

	// Bank bit of this lane
	localparam logic BANK_BIT = 1'(BANK_ID);

	logic dp_valid_q;
	logic [BEAT_IDX_W-1:0] dp_idx_q;
	logic addr_valid;

	// ======================================================================
	// Address phase
	// ======================================================================
	// line base | bank | word | byte
	assign o_haddr = {i_line_base, BANK_BIT, i_word_idx, 2'b00};
	assign o_htrans = i_htrans;
	assign o_hburst = HBURST_WRAP8;
	assign o_hsize = HSIZE_WORD;
	// Refill only reads
	assign o_hwrite = 1'b0;

	assign addr_valid = (i_htrans == NONSEQ) || (i_htrans == SEQ);

	// ======================================================================
	// Data phase
	// ======================================================================
	// hready high moves the pipeline one step, low freezes it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dp_valid_q <= 1'b0;
			dp_idx_q <= '0;
		end else if (i_hready) begin
			dp_valid_q <= addr_valid;
			if (addr_valid)
				dp_idx_q <= i_word_idx;
		end
	end

	// Completes at this edge
	assign o_beat_valid = dp_valid_q && i_hready;
	assign o_beat_err = dp_valid_q && i_hready && i_hresp;
	assign o_beat_idx = dp_idx_q;
	assign o_beat_data = i_hrdata;

	// Pending index frozen during wait states
	a_idx_on_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		$changed(dp_idx_q) |-> $past(i_hready)
	) else $error("bank_lane %0d: data-phase index moved while stalled", BANK_ID);

endmodule : bank_lane

/* hdl/burst_sequencer.sv */
`timescale 1ns/10ps

// ==========================================================================
// Burst sequencer
// Transfer state, beat count and wrapping word index of one refill
// ==========================================================================

module burst_sequencer import refill_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	// Refill request
	input  logic                   i_req,
	input  logic [ADDR_W-1:0]      i_addr,
	output logic                   o_busy,
	// From the assembler
	input  logic                   i_beat_accept,
	input  logic                   i_burst_abort,
	// To every lane
	output logic [LINE_BASE_W-1:0] o_line_base,
	output logic [BEAT_IDX_W-1:0]  o_word_idx,
	output htrans_t                o_htrans
);

	htrans_t state_q;
	htrans_t state_d;
	// Last address out, final data phase still pending
	logic drain_q;
	logic drain_d;
	logic [BEAT_IDX_W-1:0] beat_cnt_q;
	logic [LINE_BASE_W-1:0] line_base_q;
	logic [BEAT_IDX_W-1:0] word_idx_q;
	logic addr_phase;
	logic take_req;
	logic last_beat;

	// Address phase on the bus
	assign addr_phase = (state_q == NONSEQ) || (state_q == SEQ);

	// New refill only from a fully quiet sequencer
	assign take_req = (state_q == IDLE) && !drain_q && i_req;

	assign last_beat = (beat_cnt_q == BEAT_IDX_W'(BURST_LEN - 1));

	// ======================================================================
	// Next state
	// ======================================================================
	always_comb begin
		state_d = state_q;
		drain_d = drain_q;
		case (state_q)
			IDLE: begin
				if (drain_q) begin
					// Final data phase done, or bus fault on it
					if (i_beat_accept || i_burst_abort)
						drain_d = 1'b0;
				end else if (i_req) begin
					state_d = NONSEQ;
				end
			end
			NONSEQ, SEQ: begin
				if (i_burst_abort) begin
					// Drop the rest of the line
					state_d = IDLE;
				end else if (i_beat_accept) begin
					if (last_beat) begin
						state_d = IDLE;
						drain_d = 1'b1;
					end else begin
						state_d = SEQ;
					end
				end
			end
			// BUSY is never issued
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			drain_q <= 1'b0;
			beat_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			drain_q <= drain_d;
			if (take_req)
				beat_cnt_q <= '0;
			else if (addr_phase && i_beat_accept)
				beat_cnt_q <= beat_cnt_q + 1'b1;
		end
	end

	// Line base and wrapping index
	always_ff @(posedge clk) begin
		if (take_req) begin
			line_base_q <= i_addr[ADDR_W-1:6];
			word_idx_q <= i_addr[4:2];
		end else if (addr_phase && i_beat_accept) begin
			// Natural overflow gives the WRAP8 order
			word_idx_q <= word_idx_q + 1'b1;
		end
	end

	assign o_htrans = state_q;
	assign o_line_base = line_base_q;
	assign o_word_idx = word_idx_q;
	assign o_busy = (state_q != IDLE) || drain_q;

	// ======================================================================
	// Checks
	// ======================================================================
	a_no_busy_trans: assert property (
		@(posedge clk) disable iff (!rst_n) o_htrans != BUSY
	) else $error("burst_sequencer: BUSY transfer issued");

	// Stalled address keeps its index
	a_idx_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(addr_phase && !i_beat_accept) |=> $stable(o_word_idx)
	) else $error("burst_sequencer: word index moved without accept");

endmodule : burst_sequencer

/* hdl/line_assembler.sv */
`timescale 1ns/10ps

// ==========================================================================
// Line assembler
// Joins the lane results into cache updates and bus errors
// ==========================================================================

module line_assembler import refill_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// Lane results
	input  logic                  i_beat_valid [NUM_BANKS],
	input  logic                  i_beat_err [NUM_BANKS],
	input  logic [BEAT_IDX_W-1:0] i_beat_idx [NUM_BANKS],
	input  logic [DATA_W-1:0]     i_beat_data [NUM_BANKS],
	input  logic                  i_hready [NUM_BANKS],
	// Refill in progress
	input  logic                  i_active,
	// Back to the sequencer
	output logic                  o_beat_accept,
	output logic                  o_burst_abort,
	// Cache update
	output logic                  o_upd_valid,
	output logic [BEAT_IDX_W-1:0] o_upd_idx,
	output logic [DATA_W-1:0]     o_upd_word0,
	output logic [DATA_W-1:0]     o_upd_word1,
	output logic                  o_bus_err
);

	logic all_ready;
	logic any_ready;
	logic any_err;
	logic all_valid;
	logic same_idx;
	logic mismatch;

	// Reduce over banks
	always_comb begin
		all_ready = 1'b1;
		any_ready = 1'b0;
		any_err = 1'b0;
		all_valid = 1'b1;
		same_idx = 1'b1;
		for (int b = 0; b < NUM_BANKS; b++) begin
			all_ready &= i_hready[b];
			any_ready |= i_hready[b];
			any_err |= i_beat_err[b];
			all_valid &= i_beat_valid[b];
			if (i_beat_idx[b] != i_beat_idx[0])
				same_idx = 1'b0;
		end
	end

	// Banks out of step
	assign mismatch = any_ready && !all_ready;

	assign o_beat_accept = all_ready && !any_err;
	assign o_burst_abort = i_active && (mismatch || any_err);
	assign o_bus_err = o_burst_abort;

	// Both halves of the same word pair
	assign o_upd_valid = i_active && all_valid && same_idx && o_beat_accept;
	assign o_upd_idx = i_beat_idx[0];
	// Bank 0 lower half-line, bank 1 upper
	assign o_upd_word0 = i_beat_data[0];
	assign o_upd_word1 = i_beat_data[1];

	// Lanes must stay in lockstep
	a_lane_lockstep: assert property (
		@(posedge clk) disable iff (!rst_n)
		(i_active && all_valid) |-> same_idx
	) else $error("line_assembler: lanes valid with different indices");

endmodule : line_assembler

/* hdl/refill_pkg.sv */
// ==========================================================================
// Shared widths, burst constants and AHB encodings
// ==========================================================================

package refill_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Two banks side by side, each one serving half of the line
	localparam int NUM_BANKS = 2;

	// One line refill is a single eight-beat burst
	localparam int BURST_LEN = 8;
	localparam int BEAT_IDX_W = 3;

	// Line identity sits above the bank bit
	// 2 byte bits + 3 word bits + 1 bank bit below it
	localparam int LINE_BASE_W = ADDR_W - 6;

	// ======================================================================
	// AHB attribute codes
	// ======================================================================

	// Eight-beat wrapping burst
	localparam logic [2:0] HBURST_WRAP8 = 3'b100;

	// 32-bit transfer
	localparam logic [2:0] HSIZE_WORD = 3'b010;

	// Transfer type, standard 2-bit encoding
	// BUSY exists for completeness only
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

endpackage : refill_pkg

/* hdl/refill_top.sv */
`timescale 1ns/10ps

// ==========================================================================
// Instruction-cache refill master on two AHB banks
// ==========================================================================

module refill_top import refill_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// Refill request
	input  logic                  i_req,
	input  logic [ADDR_W-1:0]     i_addr,
	output logic                  o_busy,
	// AHB banks
	input  logic                  i_hready [NUM_BANKS],
	input  logic                  i_hresp [NUM_BANKS],
	input  logic [DATA_W-1:0]     i_hrdata [NUM_BANKS],
	output logic [ADDR_W-1:0]     o_haddr [NUM_BANKS],
	output htrans_t               o_htrans [NUM_BANKS],
	output logic [2:0]            o_hburst [NUM_BANKS],
	output logic [2:0]            o_hsize [NUM_BANKS],
	output logic                  o_hwrite [NUM_BANKS],
	// Cache update
	output logic                  o_upd_valid,
	output logic [BEAT_IDX_W-1:0] o_upd_idx,
	output logic [DATA_W-1:0]     o_upd_word0,
	output logic [DATA_W-1:0]     o_upd_word1,
	output logic                  o_bus_err
);

	// Sequencer to lanes
	logic [LINE_BASE_W-1:0] line_base;
	logic [BEAT_IDX_W-1:0] word_idx;
	htrans_t htrans;
	// Lanes to assembler
	logic beat_valid [NUM_BANKS];
	logic beat_err [NUM_BANKS];
	logic [BEAT_IDX_W-1:0] beat_idx [NUM_BANKS];
	logic [DATA_W-1:0] beat_data [NUM_BANKS];
	// Assembler to sequencer
	logic beat_accept;
	logic burst_abort;

	burst_sequencer i_burst_sequencer (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_req         (i_req),
		.i_addr        (i_addr),
		.o_busy        (o_busy),
		.i_beat_accept (beat_accept),
		.i_burst_abort (burst_abort),
		.o_line_base   (line_base),
		.o_word_idx    (word_idx),
		.o_htrans      (htrans)
	);

	// One lane per bank
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_lane
		bank_lane #(
			.BANK_ID (b)
		) i_bank_lane (
			.clk          (clk),
			.rst_n        (rst_n),
			.i_line_base  (line_base),
			.i_word_idx   (word_idx),
			.i_htrans     (htrans),
			.i_hready     (i_hready[b]),
			.i_hresp      (i_hresp[b]),
			.i_hrdata     (i_hrdata[b]),
			.o_haddr      (o_haddr[b]),
			.o_htrans     (o_htrans[b]),
			.o_hburst     (o_hburst[b]),
			.o_hsize      (o_hsize[b]),
			.o_hwrite     (o_hwrite[b]),
			.o_beat_valid (beat_valid[b]),
			.o_beat_idx   (beat_idx[b]),
			.o_beat_err   (beat_err[b]),
			.o_beat_data  (beat_data[b])
		);
	end

	line_assembler i_line_assembler (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_beat_valid  (beat_valid),
		.i_beat_err    (beat_err),
		.i_beat_idx    (beat_idx),
		.i_beat_data   (beat_data),
		.i_hready      (i_hready),
		.i_active      (o_busy),
		.o_beat_accept (beat_accept),
		.o_burst_abort (burst_abort),
		.o_upd_valid   (o_upd_valid),
		.o_upd_idx     (o_upd_idx),
		.o_upd_word0   (o_upd_word0),
		.o_upd_word1   (o_upd_word1),
		.o_bus_err     (o_bus_err)
	);

endmodule : refill_top

/* run_sim.sh */
#!/bin/sh
# Compile and run the refill testbench with Verilator, result taken from the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_refill_top -f build.f \
	-o tb_refill_top && ./obj_dir/tb_refill_top > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^TEST OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/ahb_bank_model.sv */
`timescale 1ns/10ps

// ==========================================================================
// Behavioral AHB slave for one bank
// Wait states and error responses come from the testbench controls
// ==========================================================================

module ahb_bank_model import refill_pkg::*; #(
	// Memory word at byte address A is A XOR this key
	parameter logic [DATA_W-1:0] FILL_KEY = 32'h5A5A0000
) (
	input  logic              clk,
	input  logic              rst_n,
	// Master side
	input  logic [ADDR_W-1:0] i_haddr,
	input  htrans_t           i_htrans,
	// Shared wait pattern and fault controls
	input  logic              i_stall,
	input  logic              i_force_ready,
	input  logic              i_err,
	// Slave response
	output logic              o_hready,
	output logic              o_hresp,
	output logic [DATA_W-1:0] o_hrdata
);

	logic dp_valid;
	logic [ADDR_W-1:0] dp_addr;
	logic addr_valid;

	assign addr_valid = (i_htrans == NONSEQ) || (i_htrans == SEQ);

	// Forced ready overrides the shared wait pattern
	assign o_hready = i_force_ready || !i_stall;
	assign o_hresp = i_err;

	// ======================================================================
	// Data phase tracking
	// ======================================================================
	// Address accepted when ready, held while waiting
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dp_valid <= 1'b0;
			dp_addr <= '0;
		end else if (o_hready) begin
			dp_valid <= addr_valid;
			if (addr_valid)
				dp_addr <= i_haddr;
		end
	end

	// Read data put on the bus half a cycle ahead of the sampling edge
	always @(negedge clk) begin
		if (dp_valid)
			o_hrdata <= dp_addr ^ FILL_KEY;
		else
			o_hrdata <= '0;
	end

endmodule : ahb_bank_model

/* sim/tb_refill_top.sv */
`timescale 1ns/10ps

// ==========================================================================
// Testbench for the instruction-cache refill master
// ==========================================================================

module tb_refill_top import refill_pkg::*; #(
	parameter int NUM_REQ = 40,
	// Every beat with up to four wait cycles, plus margin
	parameter int MAX_CYCLES = NUM_REQ * BURST_LEN * 4 + 500
);

	typedef enum int {
		FAULT_NONE,
		FAULT_MISMATCH,
		FAULT_RESP
	} fault_e;

	// DUT ports
	logic clk;
	logic rst_n;
	logic i_req;
	logic [ADDR_W-1:0] i_addr;
	logic o_busy;
	logic i_hready [NUM_BANKS];
	logic i_hresp [NUM_BANKS];
	logic [DATA_W-1:0] i_hrdata [NUM_BANKS];
	logic [ADDR_W-1:0] o_haddr [NUM_BANKS];
	htrans_t o_htrans [NUM_BANKS];
	logic [2:0] o_hburst [NUM_BANKS];
	logic [2:0] o_hsize [NUM_BANKS];
	logic o_hwrite [NUM_BANKS];
	logic o_upd_valid;
	logic [BEAT_IDX_W-1:0] o_upd_idx;
	logic [DATA_W-1:0] o_upd_word0;
	logic [DATA_W-1:0] o_upd_word1;
	logic o_bus_err;

	// Slave controls
	logic stall;
	logic force_ready [NUM_BANKS];
	logic err_drv [NUM_BANKS];
	// Fault on the bus this cycle
	logic fault;

	// Scoreboard state
	logic [LINE_BASE_W-1:0] exp_base;
	logic [BEAT_IDX_W-1:0] exp_addr_idx;
	logic [BEAT_IDX_W-1:0] exp_upd_idx;
	logic first_addr;
	logic aborted;
	logic addr_both;
	htrans_t exp_htrans;
	int addr_cnt;
	int upd_cnt;
	int err_seen;
	int cycle_cnt;

	refill_top i_refill_top (.*);

	always #10 clk = ~clk;

	// Bank memory contents
	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
		return a ^ 32'h5A5A0000;
	endfunction

	task automatic value_error(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp_v, act_v);
		$display("TEST FAILED");
		$fatal(1, "value check failed");
	endtask

	task automatic text_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "protocol check failed");
	endtask

	// ======================================================================
	// Bank models and per-bank address checks
	// ======================================================================
	assign exp_htrans = first_addr ? NONSEQ : SEQ;
	assign addr_both = ((o_htrans[0] == NONSEQ) || (o_htrans[0] == SEQ)) &&
		i_hready[0] && i_hready[1];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic acc;
		logic [ADDR_W-1:0] exp_haddr;

		assign acc = ((o_htrans[b] == NONSEQ) || (o_htrans[b] == SEQ)) && i_hready[b];
		// Bank bit selects the half-line
		assign exp_haddr = {exp_base, 1'(b), exp_addr_idx, 2'b00};

		ahb_bank_model i_ahb_bank_model (
			.clk           (clk),
			.rst_n         (rst_n),
			.i_haddr       (o_haddr[b]),
			.i_htrans      (o_htrans[b]),
			.i_stall       (stall),
			.i_force_ready (force_ready[b]),
			.i_err         (err_drv[b]),
			.o_hready      (i_hready[b]),
			.o_hresp       (i_hresp[b]),
			.o_hrdata      (i_hrdata[b])
		);

		a_htrans: assert property (@(posedge clk) disable iff (!rst_n)
			acc |-> o_htrans[b] == exp_htrans)
			else value_error($sformatf("o_htrans[%0d]", b), 32'($sampled(exp_htrans)),
				32'($sampled(o_htrans[b])));
		a_haddr: assert property (@(posedge clk) disable iff (!rst_n)
			acc |-> o_haddr[b] == exp_haddr)
			else value_error($sformatf("o_haddr[%0d]", b), $sampled(exp_haddr),
				$sampled(o_haddr[b]));
		a_hburst: assert property (@(posedge clk) disable iff (!rst_n)
			acc |-> o_hburst[b] == HBURST_WRAP8)
			else value_error($sformatf("o_hburst[%0d]", b), 32'(HBURST_WRAP8),
				32'($sampled(o_hburst[b])));
		a_hsize: assert property (@(posedge clk) disable iff (!rst_n)
			acc |-> o_hsize[b] == HSIZE_WORD)
			else value_error($sformatf("o_hsize[%0d]", b), 32'(HSIZE_WORD),
				32'($sampled(o_hsize[b])));
		a_hwrite: assert property (@(posedge clk) disable iff (!rst_n)
			acc |-> !o_hwrite[b])
			else value_error($sformatf("o_hwrite[%0d]", b), 32'd0,
				32'($sampled(o_hwrite[b])));
	end

	// ======================================================================
	// Update, end-of-burst and fault checks
	// ======================================================================
	a_reset: assert property (@(posedge clk)
		!rst_n |-> (o_htrans[0] == IDLE) && (o_htrans[1] == IDLE) && !o_busy &&
		!o_upd_valid && !o_bus_err)
		else text_error("outputs not idle during reset");
	a_first: assert property (@(posedge clk) disable iff (!rst_n)
		(i_req && !o_busy) |=> o_htrans[0] == NONSEQ)
		else value_error("o_htrans[0]", 32'(NONSEQ), 32'($sampled(o_htrans[0])));
	a_upd_idx: assert property (@(posedge clk) disable iff (!rst_n)
		o_upd_valid |-> o_upd_idx == exp_upd_idx)
		else value_error("o_upd_idx", 32'($sampled(exp_upd_idx)), 32'($sampled(o_upd_idx)));
	a_word0: assert property (@(posedge clk) disable iff (!rst_n)
		o_upd_valid |-> o_upd_word0 == mem_word({exp_base, 1'b0, exp_upd_idx, 2'b00}))
		else value_error("o_upd_word0",
			mem_word({$sampled(exp_base), 1'b0, $sampled(exp_upd_idx), 2'b00}),
			$sampled(o_upd_word0));
	a_word1: assert property (@(posedge clk) disable iff (!rst_n)
		o_upd_valid |-> o_upd_word1 == mem_word({exp_base, 1'b1, exp_upd_idx, 2'b00}))
		else value_error("o_upd_word1",
			mem_word({$sampled(exp_base), 1'b1, $sampled(exp_upd_idx), 2'b00}),
			$sampled(o_upd_word1));
	a_upd_count: assert property (@(posedge clk) disable iff (!rst_n)
		o_upd_valid |-> (upd_cnt < BURST_LEN) && !aborted)
		else text_error("update after the eighth beat or after an abort");
	a_upd_ready: assert property (@(posedge clk) disable iff (!rst_n)
		o_upd_valid |-> i_hready[0] && i_hready[1])
		else text_error("update in a cycle with hready low");
	a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
		(o_upd_valid && (upd_cnt == BURST_LEN - 1)) |=> !o_busy)
		else value_error("o_busy", 32'd0, 32'($sampled(o_busy)));
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(o_busy) |-> (upd_cnt == BURST_LEN) || aborted)
		else text_error("o_busy fell before eight updates without a bus error");
	a_bus_err: assert property (@(posedge clk) disable iff (!rst_n)
		o_bus_err == fault)
		else value_error("o_bus_err", 32'($sampled(fault)), 32'($sampled(o_bus_err)));
	a_fault_idle: assert property (@(posedge clk) disable iff (!rst_n)
		fault |-> !o_upd_valid ##1 (o_htrans[0] == IDLE) && (o_htrans[1] == IDLE))
		else text_error("burst not dropped after a bus error");

	// Expected burst position, taken from the DUT's bus activity
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_addr <= 1'b0;
			aborted <= 1'b0;
			addr_cnt <= 0;
			upd_cnt <= 0;
			err_seen <= 0;
		end else if (i_req && !o_busy) begin
			exp_base <= i_addr[ADDR_W-1:6];
			exp_addr_idx <= i_addr[4:2];
			exp_upd_idx <= i_addr[4:2];
			first_addr <= 1'b1;
			aborted <= 1'b0;
			addr_cnt <= 0;
			upd_cnt <= 0;
		end else begin
			if (addr_both) begin
				first_addr <= 1'b0;
				exp_addr_idx <= exp_addr_idx + 1'b1;
				addr_cnt <= addr_cnt + 1;
			end
			if (o_upd_valid) begin
				exp_upd_idx <= exp_upd_idx + 1'b1;
				upd_cnt <= upd_cnt + 1;
			end
			if (o_bus_err) begin
				aborted <= 1'b1;
				err_seen <= err_seen + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: no end of run within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic release_bus();
		stall = 1'b0;
		fault = 1'b0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			force_ready[b] = 1'b0;
			err_drv[b] = 1'b0;
		end
	endtask

	// One refill, optionally with a fault at a random beat
	task automatic run_refill(input fault_e kind, input bit waits);
		int inj_beat;
		int bank;
		bit injected;
		inj_beat = $urandom % BURST_LEN;
		bank = $urandom % NUM_BANKS;
		injected = 1'b0;
		@(negedge clk);
		i_req = 1'b1;
		i_addr = $urandom;
		@(negedge clk);
		// Taken on the edge just passed
		i_req = 1'b0;
		i_addr = $urandom;
		while (o_busy) begin
			stall = waits && (($urandom % 4) == 0);
			if (!injected && (kind != FAULT_NONE) && (upd_cnt == inj_beat)) begin
				if (kind == FAULT_MISMATCH) begin
					// Bank 0 waits, bank 1 claims ready
					stall = 1'b1;
					force_ready[1] = 1'b1;
					fault = 1'b1;
					injected = 1'b1;
				end else if (addr_cnt > upd_cnt) begin
					// Needs a data phase in flight
					stall = 1'b0;
					err_drv[bank] = 1'b1;
					fault = 1'b1;
					injected = 1'b1;
				end
			end
			@(negedge clk);
		end
		release_bus();
	endtask

	initial begin
		fault_e kind;
		int exp_errs;
		void'($urandom(32'h049e7571));
		exp_errs = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		i_req = 1'b0;
		i_addr = '0;
		release_bus();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		// First few without wait states, then random waits and periodic faults
		for (int n = 0; n < NUM_REQ; n++) begin
			kind = (n % 10 == 7) ? FAULT_MISMATCH : (n % 10 == 3) ? FAULT_RESP : FAULT_NONE;
			run_refill(kind, n >= 4);
			if (kind != FAULT_NONE)
				exp_errs++;
		end
		repeat (2) @(negedge clk);
		if (err_seen != exp_errs) begin
			$display("Saw %0d bus errors for %0d injected faults", err_seen, exp_errs);
			$display("TEST FAILED");
			$fatal(1, "bus error count wrong");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule : tb_refill_top
